/* source/adpcm_pkg.sv */
package adpcm_pkg;

	// ====================
	// Widths
	// ====================

	// Sample memory is 32 MiB, addressed by byte
	localparam int ROM_BYTE_AW  = 25;
	localparam int ROM_WORD_AW  = ROM_BYTE_AW - 1;
	localparam int ROM_WORD_W   = 16;
	localparam int SAMPLE_W     = 8;
	localparam int ADPCMA_AW    = 20;
	localparam int ADPCMA_BW    = 4;
	localparam int ADPCMB_AW    = 24;
	localparam int LOAD_INDEX_W = 8;
	localparam int LOAD_AW      = 25;

	// ====================
	// Types
	// ====================

	typedef logic [ROM_BYTE_AW-1:0]  rom_byte_addr_t;
	typedef logic [ROM_WORD_AW-1:0]  rom_word_addr_t;
	typedef logic [ROM_WORD_W-1:0]   rom_word_t;
	typedef logic [SAMPLE_W-1:0]     sample_byte_t;
	typedef logic [ADPCMA_AW-1:0]    adpcma_addr_t;
	typedef logic [ADPCMA_BW-1:0]    adpcma_bank_t;
	typedef logic [ADPCMB_AW-1:0]    adpcmb_addr_t;
	typedef logic [LOAD_INDEX_W-1:0] load_index_t;
	typedef logic [LOAD_AW-1:0]      load_addr_t;
	// 0 console, 1 arcade, 2/3 CD variants (bit 1 marks CD)
	typedef logic [1:0]              system_type_t;

	// ====================
	// Constants
	// ====================

	// Sample ROM download window, upper bound excluded
	localparam load_index_t INDEX_VROMS = 8'd16;
	localparam load_index_t INDEX_CROMS = 8'd64;
	// Each index step is a 512 KiB slice
	localparam int LOAD_STEP_BITS = 19;
	// CD systems have no ADPCM-B ROM, chip sees a constant
	localparam sample_byte_t CD_FILL_BYTE = 8'h08;

endpackage

/* source/sample_fetch_if.sv */
`timescale 1ns/1ps

// Link between one sample channel and the shared DDR read arbiter
interface sample_fetch_if import adpcm_pkg::*; ();

	// Request side, owned by the channel
	logic           pending;
	rom_byte_addr_t addr;

	// Response side, owned by the arbiter
	logic           grant;
	sample_byte_t   data;
	logic           data_valid;

	modport channel (
		output pending,
		output addr,
		input  grant,
		input  data,
		input  data_valid
	);

	modport arbiter (
		input  pending,
		input  addr,
		output grant,
		output data,
		output data_valid
	);

endinterface

/* source/fetch_config.sv */
`timescale 1ns/1ps

module fetch_config import adpcm_pkg::*; (
	input  logic           clk_sys,
	input  logic           nRESET,
	input  system_type_t   cfg_system_type,
	input  logic           cfg_use_pcm,
	input  adpcma_addr_t   adpcma_addr,
	input  adpcma_bank_t   adpcma_bank,
	input  adpcmb_addr_t   adpcmb_addr,
	input  logic           ioctl_download,
	input  load_index_t    ioctl_index,
	input  load_addr_t     ioctl_addr,
	output logic           cd_system,
	output rom_byte_addr_t a_byte_addr,
	output rom_byte_addr_t b_byte_addr,
	output logic           load_active,
	output rom_byte_addr_t load_addr
);

	logic         cfg_taken;
	system_type_t system_type;
	logic         use_pcm;
	load_index_t  load_step;

	// Settings are sampled once, on the first edge out of reset
	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			cfg_taken   <= 1'b0;
			system_type <= '0;
			use_pcm     <= 1'b0;
		end
		else if (!cfg_taken)
		begin
			cfg_taken   <= 1'b1;
			system_type <= cfg_system_type;
			use_pcm     <= cfg_use_pcm;
		end
	end

	// Both CD variants share the upper type bit
	assign cd_system = system_type[1];

	// ADPCM-A lives in the lower 16 MiB, bank on top of the chip address
	assign a_byte_addr = {1'b0, adpcma_bank, adpcma_addr};
	// ADPCM-B goes to the upper half unless the PCM chip is in use
	assign b_byte_addr = {~use_pcm, adpcmb_addr};

	// Download window for sample ROMs
	assign load_active = ioctl_download && (ioctl_index >= INDEX_VROMS)
		&& (ioctl_index < INDEX_CROMS);
	assign load_step = ioctl_index - INDEX_VROMS;
	assign load_addr = ioctl_addr + (rom_byte_addr_t'(load_step) << LOAD_STEP_BITS);

endmodule

/* source/sample_channel.sv */
`timescale 1ns/1ps

module sample_channel import adpcm_pkg::*; #(
	parameter bit CD_MUTE = 1'b0
) (
	input  logic           clk_sys,
	input  logic           nRESET,
	input  logic           roe_n,
	input  rom_byte_addr_t byte_addr,
	input  logic           cd_system,
	output sample_byte_t   sample,
	sample_fetch_if.channel fetch
);

	logic [1:0]     oe_sr;
	logic           oe_fall;
	logic           muted;
	logic           pending;
	rom_byte_addr_t addr_hold;
	sample_byte_t   sample_q;

	// Channel goes silent on CD systems when built as mutable
	assign muted = CD_MUTE && cd_system;
	// Old sample high, new sample low
	assign oe_fall = (oe_sr == 2'b10) && !muted;

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			oe_sr    <= 2'b11;
			pending  <= 1'b0;
			sample_q <= '0;
		end
		else
		begin
			oe_sr <= {oe_sr[0], roe_n};
			// A fresh edge wins over a grant in the same cycle
			if (oe_fall)
				pending <= 1'b1;
			else if (fetch.grant)
				pending <= 1'b0;
			if (fetch.data_valid)
				sample_q <= fetch.data;
		end
	end

	// Newest address is kept, repeated edges coalesce
	always_ff @(posedge clk_sys)
	begin
		if (oe_fall)
			addr_hold <= byte_addr;
	end

	assign fetch.pending = pending;
	assign fetch.addr    = addr_hold;
	assign sample        = muted ? CD_FILL_BYTE : sample_q;

	// Arbiter only grants a channel that asked
	a_grant_needs_pending: assert property (@(posedge clk_sys) disable iff (!nRESET)
		fetch.grant |-> pending);

endmodule

/* source/rom_read_arbiter.sv */
`timescale 1ns/1ps

module rom_read_arbiter import adpcm_pkg::*; (
	input  logic           clk_sys,
	input  logic           nRESET,
	input  rom_word_t      ddr_rd_data,
	input  logic           ddr_rd_ack,
	output rom_word_addr_t ddr_rd_addr,
	output logic           ddr_rd_req,
	sample_fetch_if.arbiter chan_a,
	sample_fetch_if.arbiter chan_b
);

	logic           wait_a;
	logic           wait_b;
	logic           idle;
	logic           grant_a;
	logic           grant_b;
	logic           rd_done;
	logic           valid_a;
	logic           valid_b;
	rom_byte_addr_t addr_q;
	sample_byte_t   byte_sel;
	sample_byte_t   data_q;

	// ====================
	// Selection
	// ====================

	// One read in flight at a time
	assign idle = !wait_a && !wait_b;
	// B first, its sample rate can be higher than A
	assign grant_b = idle && chan_b.pending;
	assign grant_a = idle && !chan_b.pending && chan_a.pending;
	// Toggle handshake closed, word on ddr_rd_data is valid
	assign rd_done = !idle && (ddr_rd_req == ddr_rd_ack);
	// Odd byte address takes the upper half of the word
	assign byte_sel = addr_q[0] ? ddr_rd_data[15:8] : ddr_rd_data[7:0];

	// ====================
	// Request and return
	// ====================

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			wait_a     <= 1'b0;
			wait_b     <= 1'b0;
			ddr_rd_req <= 1'b0;
			valid_a    <= 1'b0;
			valid_b    <= 1'b0;
		end
		else
		begin
			valid_a <= rd_done && wait_a;
			valid_b <= rd_done && wait_b;
			if (grant_a || grant_b)
			begin
				ddr_rd_req <= ~ddr_rd_req;
				wait_a     <= grant_a;
				wait_b     <= grant_b;
			end
			else if (rd_done)
			begin
				wait_a <= 1'b0;
				wait_b <= 1'b0;
			end
		end
	end

	// Address and returned byte
	always_ff @(posedge clk_sys)
	begin
		if (grant_b)
			addr_q <= chan_b.addr;
		else if (grant_a)
			addr_q <= chan_a.addr;
		if (rd_done)
			data_q <= byte_sel;
	end

	assign ddr_rd_addr       = addr_q[ROM_BYTE_AW-1:1];
	assign chan_a.grant      = grant_a;
	assign chan_b.grant      = grant_b;
	assign chan_a.data       = data_q;
	assign chan_b.data       = data_q;
	assign chan_a.data_valid = valid_a;
	assign chan_b.data_valid = valid_b;

	a_one_owner: assert property (@(posedge clk_sys) disable iff (!nRESET)
		!(wait_a && wait_b));
	// No second request until memory answers the first
	a_req_held: assert property (@(posedge clk_sys) disable iff (!nRESET)
		(ddr_rd_req != ddr_rd_ack) |=> $stable(ddr_rd_req));

endmodule

/* source/rom_load_writer.sv */
`timescale 1ns/1ps

module rom_load_writer import adpcm_pkg::*; (
	input  logic           clk_sys,
	input  logic           nRESET,
	input  logic           load_active,
	input  rom_byte_addr_t load_addr,
	input  logic           ioctl_wr,
	input  rom_word_t      ioctl_dout,
	input  logic           ddr_we_ack,
	output rom_word_addr_t ddr_wr_addr,
	output rom_word_t      ddr_wr_data,
	output logic           ddr_we_req,
	output logic           ioctl_wait
);

	logic wr_take;
	logic wait_q;

	// Only sample ROM indices go to DDR
	assign wr_take = load_active && ioctl_wr;

	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			ddr_we_req <= 1'b0;
			wait_q     <= 1'b0;
		end
		else if (wr_take)
		begin
			// New write, hold the host until DDR answers
			ddr_we_req <= ~ddr_we_req;
			wait_q     <= 1'b1;
		end
		else if (!load_active)
			wait_q <= 1'b0;
		else if (wait_q && (ddr_we_req == ddr_we_ack))
			wait_q <= 1'b0;
	end

	// Word address and data held for the whole handshake
	always_ff @(posedge clk_sys)
	begin
		if (wr_take)
		begin
			ddr_wr_addr <= load_addr[ROM_BYTE_AW-1:1];
			ddr_wr_data <= ioctl_dout;
		end
	end

	assign ioctl_wait = wait_q;

	// Host must honour the wait level
	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (!nRESET)
		ioctl_wr |-> !wait_q);

endmodule

/* source/adpcm_fetch_top.sv */
`timescale 1ns/1ps

module adpcm_fetch_top import adpcm_pkg::*; (
	input  logic           clk_sys,
	input  logic           nRESET,
	input  system_type_t   cfg_system_type,
	input  logic           cfg_use_pcm,
	// Sound chip ROM ports
	input  adpcma_addr_t   adpcma_addr,
	input  adpcma_bank_t   adpcma_bank,
	input  logic           adpcma_roe_n,
	output sample_byte_t   adpcma_data,
	input  adpcmb_addr_t   adpcmb_addr,
	input  logic           adpcmb_roe_n,
	output sample_byte_t   adpcmb_data,
	// DDR read side
	output rom_word_addr_t ddr_rd_addr,
	output logic           ddr_rd_req,
	input  rom_word_t      ddr_rd_data,
	input  logic           ddr_rd_ack,
	// DDR write side
	output rom_word_addr_t ddr_wr_addr,
	output rom_word_t      ddr_wr_data,
	output logic           ddr_we_req,
	input  logic           ddr_we_ack,
	// Host download stream
	input  logic           ioctl_download,
	input  logic           ioctl_wr,
	input  load_addr_t     ioctl_addr,
	input  load_index_t    ioctl_index,
	input  rom_word_t      ioctl_dout,
	output logic           ioctl_wait
);

	logic           cd_system;
	logic           load_active;
	rom_byte_addr_t a_byte_addr;
	rom_byte_addr_t b_byte_addr;
	rom_byte_addr_t load_addr;

	sample_fetch_if fetch_a ();
	sample_fetch_if fetch_b ();

	fetch_config fetch_config_inst (
		.clk_sys, .nRESET, .cfg_system_type, .cfg_use_pcm,
		.adpcma_addr, .adpcma_bank, .adpcmb_addr,
		.ioctl_download, .ioctl_index, .ioctl_addr,
		.cd_system, .a_byte_addr, .b_byte_addr, .load_active, .load_addr
	);

	// ADPCM-A always plays, ADPCM-B is muted on CD
	sample_channel #(.CD_MUTE(1'b0)) chan_a (
		.clk_sys, .nRESET, .roe_n(adpcma_roe_n), .byte_addr(a_byte_addr),
		.cd_system, .sample(adpcma_data), .fetch(fetch_a.channel)
	);

	sample_channel #(.CD_MUTE(1'b1)) chan_b (
		.clk_sys, .nRESET, .roe_n(adpcmb_roe_n), .byte_addr(b_byte_addr),
		.cd_system, .sample(adpcmb_data), .fetch(fetch_b.channel)
	);

	rom_read_arbiter rom_read_arbiter_inst (
		.clk_sys, .nRESET, .ddr_rd_data, .ddr_rd_ack, .ddr_rd_addr, .ddr_rd_req,
		.chan_a(fetch_a.arbiter), .chan_b(fetch_b.arbiter)
	);

	rom_load_writer rom_load_writer_inst (
		.clk_sys, .nRESET, .load_active, .load_addr, .ioctl_wr, .ioctl_dout,
		.ddr_we_ack, .ddr_wr_addr, .ddr_wr_data, .ddr_we_req, .ioctl_wait
	);

endmodule

/* tests/tb_adpcm_fetch.sv */
`timescale 1ns/1ps

module tb_adpcm_fetch import adpcm_pkg::*; ();

	localparam int TIMEOUT = 200;
	localparam int LOG_DEPTH = 64;
	localparam rom_word_t FILL_KEY = 16'hC35A;

	logic           clk_sys;
	logic           nRESET;
	system_type_t   cfg_system_type;
	logic           cfg_use_pcm;
	adpcma_addr_t   adpcma_addr;
	adpcma_bank_t   adpcma_bank;
	logic           adpcma_roe_n;
	sample_byte_t   adpcma_data;
	adpcmb_addr_t   adpcmb_addr;
	logic           adpcmb_roe_n;
	sample_byte_t   adpcmb_data;
	rom_word_addr_t ddr_rd_addr;
	logic           ddr_rd_req;
	rom_word_t      ddr_rd_data = '0;
	logic           ddr_rd_ack = 1'b0;
	rom_word_addr_t ddr_wr_addr;
	rom_word_t      ddr_wr_data;
	logic           ddr_we_req;
	logic           ddr_we_ack = 1'b0;
	logic           ioctl_download;
	logic           ioctl_wr;
	load_addr_t     ioctl_addr;
	load_index_t    ioctl_index;
	rom_word_t      ioctl_dout;
	logic           ioctl_wait;

	// DDR model state, logs hold every request in order
	rom_word_t      mem [rom_word_addr_t];
	rom_word_addr_t rd_addr_log [0:LOG_DEPTH-1];
	rom_word_addr_t wr_addr_log [0:LOG_DEPTH-1];
	rom_word_t      wr_data_log [0:LOG_DEPTH-1];
	int             rd_count = 0;
	int             rd_done = 0;
	int             wr_count = 0;
	logic           rd_busy = 1'b0;
	logic           wr_busy = 1'b0;
	int             rd_wait = 0;
	int             wr_wait = 0;
	rom_word_addr_t rd_addr_hold;
	logic [31:0]    stim_seed = 32'd70;
	logic [31:0]    ddr_seed = 32'd70 ^ 32'h5555;

	initial
		clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;

	adpcm_fetch_top adpcm_fetch_top_inst (.*);

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Upper halves of two steps, low LCG bits are weak
	function automatic logic [31:0] next_rand();
		logic [31:0] r;
		stim_seed = lcg_step(stim_seed);
		r[31:16] = stim_seed[31:16];
		stim_seed = lcg_step(stim_seed);
		r[15:0] = stim_seed[31:16];
		return r;
	endfunction

	// Memory latency, 1 to 8 cycles
	function automatic int next_delay();
		ddr_seed = lcg_step(ddr_seed);
		return 1 + int'(ddr_seed[30:28]);
	endfunction

	// Unwritten words fold the whole address with a key
	function automatic rom_word_t model_word(input rom_word_addr_t a);
		if (mem.exists(a))
			return mem[a];
		return a[15:0] ^ {a[23:16], a[23:16]} ^ FILL_KEY;
	endfunction

	// Odd byte address is the upper half of the word
	function automatic sample_byte_t pick_byte(input rom_byte_addr_t a);
		rom_word_t w;
		w = model_word(a[ROM_BYTE_AW-1:1]);
		return a[0] ? w[15:8] : w[7:0];
	endfunction

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "Simulation stopped at first failure");
	endtask

	task automatic check_sample(input string name, input sample_byte_t exp,
		input sample_byte_t act);
		if (act !== exp)
			stop_with_error($sformatf("ERROR %s expected %02h actual %02h", name, exp, act));
	endtask

	task automatic check_word_addr(input string name, input rom_word_addr_t exp,
		input rom_word_addr_t act);
		if (act !== exp)
			stop_with_error($sformatf("ERROR %s expected %06h actual %06h", name, exp, act));
	endtask

	task automatic check_word(input string name, input rom_word_t exp, input rom_word_t act);
		if (act !== exp)
			stop_with_error($sformatf("ERROR %s expected %04h actual %04h", name, exp, act));
	endtask

	// ====================
	// DDR model
	// ====================

	// Toggle handshakes, acks driven on the falling edge
	always @(negedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			ddr_rd_ack <= 1'b0;
			ddr_we_ack <= 1'b0;
			rd_busy = 1'b0;
			wr_busy = 1'b0;
		end
		else
		begin
			if (!rd_busy && (ddr_rd_req != ddr_rd_ack))
			begin
				rd_busy = 1'b1;
				rd_wait = next_delay();
				rd_addr_hold = ddr_rd_addr;
				rd_addr_log[rd_count] <= ddr_rd_addr;
				rd_count <= rd_count + 1;
			end
			else if (rd_busy)
			begin
				rd_wait = rd_wait - 1;
				if (rd_wait == 0)
				begin
					ddr_rd_data <= model_word(rd_addr_hold);
					ddr_rd_ack <= ddr_rd_req;
					rd_done <= rd_done + 1;
					rd_busy = 1'b0;
				end
			end
			if (!wr_busy && (ddr_we_req != ddr_we_ack))
			begin
				wr_busy = 1'b1;
				wr_wait = next_delay();
			end
			else if (wr_busy)
			begin
				wr_wait = wr_wait - 1;
				if (wr_wait == 0)
				begin
					mem[ddr_wr_addr] = ddr_wr_data;
					wr_addr_log[wr_count] <= ddr_wr_addr;
					wr_data_log[wr_count] <= ddr_wr_data;
					wr_count <= wr_count + 1;
					ddr_we_ack <= ddr_we_req;
					wr_busy = 1'b0;
				end
			end
		end
	end

	// ====================
	// Stimulus
	// ====================

	// Settings taken at release, then scrambled to show they stay latched
	task automatic apply_reset(input system_type_t st, input logic pcm);
		@(negedge clk_sys);
		nRESET = 1'b0;
		cfg_system_type = st;
		cfg_use_pcm = pcm;
		repeat (4) @(negedge clk_sys);
		nRESET = 1'b1;
		@(negedge clk_sys);
		cfg_system_type = ~st;
		cfg_use_pcm = ~pcm;
		check_sample("reset ADPCM-A", '0, adpcma_data);
		check_sample("reset ADPCM-B", st[1] ? CD_FILL_BYTE : '0, adpcmb_data);
	endtask

	task automatic load_random_word();
		load_index_t    idx;
		load_addr_t     addr;
		rom_word_t      data;
		rom_byte_addr_t exp_addr;
		int             wr_idx;
		int             i;
		idx = load_index_t'(16 + next_rand() % 48);
		addr = load_addr_t'(next_rand());
		data = rom_word_t'(next_rand());
		// 512 KiB per index step above index 16
		exp_addr = addr + rom_byte_addr_t'(idx - 8'd16) * 25'h80000;
		wr_idx = wr_count;
		ioctl_index = idx;
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		if (!ioctl_wait)
			stop_with_error("ioctl_wait did not rise after a load write");
		i = 0;
		while (ioctl_wait && (i < TIMEOUT))
		begin
			@(negedge clk_sys);
			i++;
		end
		if (ioctl_wait)
			stop_with_error("Timeout, ioctl_wait stayed high after a load write");
		if (wr_count != wr_idx + 1)
			stop_with_error("ioctl_wait fell without a DDR write acknowledge");
		check_word_addr($sformatf("load index %0d address", idx), exp_addr[ROM_BYTE_AW-1:1],
			wr_addr_log[wr_idx]);
		check_word($sformatf("load index %0d data", idx), data, wr_data_log[wr_idx]);
	endtask

	task automatic pulse_oe(input logic on_a, input logic on_b);
		adpcma_roe_n = !on_a;
		adpcmb_roe_n = !on_b;
		@(negedge clk_sys);
		adpcma_roe_n = 1'b1;
		adpcmb_roe_n = 1'b1;
	endtask

	task automatic wait_read_acks(input int target, input string name);
		int i;
		i = 0;
		while ((rd_done < target) && (i < TIMEOUT))
		begin
			@(negedge clk_sys);
			i++;
		end
		if (rd_done < target)
			stop_with_error($sformatf("Timeout waiting for DDR read in %s", name));
	endtask

	// Sample lands two edges after the ack
	task automatic finish_read(input string name, input rom_byte_addr_t exp_addr,
		input logic on_b, input int req_idx);
		wait_read_acks(req_idx + 1, name);
		if (rd_count != req_idx + 1)
			stop_with_error($sformatf("%s issued an unexpected extra DDR read", name));
		check_word_addr(name, exp_addr[ROM_BYTE_AW-1:1], rd_addr_log[req_idx]);
		repeat (2) @(negedge clk_sys);
		check_sample(name, pick_byte(exp_addr), on_b ? adpcmb_data : adpcma_data);
	endtask

	task automatic run_fetch_a(input string name);
		int req_idx;
		adpcma_bank = adpcma_bank_t'(next_rand());
		adpcma_addr = adpcma_addr_t'(next_rand());
		req_idx = rd_count;
		pulse_oe(1'b1, 1'b0);
		finish_read(name, {1'b0, adpcma_bank, adpcma_addr}, 1'b0, req_idx);
	endtask

	// Top bit selects the upper 16 MiB unless the PCM chip is used
	task automatic run_fetch_b(input string name, input logic pcm);
		int req_idx;
		adpcmb_addr = adpcmb_addr_t'(next_rand());
		req_idx = rd_count;
		pulse_oe(1'b0, 1'b1);
		finish_read(name, {~pcm, adpcmb_addr}, 1'b1, req_idx);
	endtask

	task automatic run_priority(input logic pcm);
		rom_byte_addr_t a_addr;
		rom_byte_addr_t b_addr;
		int             req_idx;
		adpcma_bank = adpcma_bank_t'(next_rand());
		adpcma_addr = adpcma_addr_t'(next_rand());
		adpcmb_addr = adpcmb_addr_t'(next_rand());
		a_addr = {1'b0, adpcma_bank, adpcma_addr};
		b_addr = {~pcm, adpcmb_addr};
		req_idx = rd_count;
		pulse_oe(1'b1, 1'b1);
		wait_read_acks(req_idx + 2, "priority");
		check_word_addr("priority first read B", b_addr[ROM_BYTE_AW-1:1], rd_addr_log[req_idx]);
		check_word_addr("priority second read A", a_addr[ROM_BYTE_AW-1:1],
			rd_addr_log[req_idx + 1]);
		repeat (2) @(negedge clk_sys);
		check_sample("priority ADPCM-B", pick_byte(b_addr), adpcmb_data);
		check_sample("priority ADPCM-A", pick_byte(a_addr), adpcma_data);
	endtask

	// Observation window, a muted B edge must stay silent
	task automatic check_cd_mute();
		int req_idx;
		int i;
		adpcmb_addr = adpcmb_addr_t'(next_rand());
		req_idx = rd_count;
		pulse_oe(1'b0, 1'b1);
		for (i = 0; i < 12; i++)
		begin
			@(negedge clk_sys);
			if (rd_count != req_idx)
				stop_with_error("ADPCM-B edge raised a DDR read on a CD system");
			check_sample("CD ADPCM-B fill", CD_FILL_BYTE, adpcmb_data);
		end
	endtask

	initial
	begin : stimulus
		int i;
		nRESET = 1'b0;
		cfg_system_type = 2'd0;
		cfg_use_pcm = 1'b0;
		adpcma_addr = '0;
		adpcma_bank = '0;
		adpcma_roe_n = 1'b1;
		adpcmb_addr = '0;
		adpcmb_roe_n = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_index = '0;
		ioctl_dout = '0;
		apply_reset(2'd0, 1'b0);

		// Sample ROM download
		ioctl_download = 1'b1;
		for (i = 0; i < 12; i++)
			load_random_word();
		@(negedge clk_sys);
		ioctl_download = 1'b0;

		// Console, PCM option off
		for (i = 0; i < 6; i++)
			run_fetch_a("ADPCM-A fetch");
		for (i = 0; i < 4; i++)
			run_fetch_b("ADPCM-B fetch PCM off", 1'b0);

		// Console, PCM option on
		apply_reset(2'd0, 1'b1);
		for (i = 0; i < 4; i++)
			run_fetch_b("ADPCM-B fetch PCM on", 1'b1);
		for (i = 0; i < 3; i++)
			run_priority(1'b1);

		// CD system, B muted
		apply_reset(2'd2, 1'b0);
		check_cd_mute();
		for (i = 0; i < 4; i++)
			run_fetch_a("ADPCM-A fetch on CD");

		$display("No errors");
		$finish;
	end

endmodule

/* compile.f */
source/adpcm_pkg.sv
source/sample_fetch_if.sv
source/fetch_config.sv
source/sample_channel.sv
source/rom_read_arbiter.sv
source/rom_load_writer.sv
source/adpcm_fetch_top.sv
tests/tb_adpcm_fetch.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_adpcm_fetch
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
